/* design/decodePkg.sv */
package decodePkg;

   // Width of every architectural register and of every data word on the stage
   localparam int dataWidth = 16;

   // Eight registers need a three bit index
   localparam int regAddrWidth = 3;

   // The opcode occupies the top five bits of the instruction word
   localparam int opcodeWidth = 5;

   // Jump-and-link instructions place their return address in register 7
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

   // JAL jumps to a PC relative target
   localparam logic [opcodeWidth-1:0] opJal = 5'b00110;

   // JALR jumps to a register based target
   localparam logic [opcodeWidth-1:0] opJalr = 5'b00111;

   // Every conditional branch shares these upper three opcode bits
   localparam logic [2:0] branchClass = 3'b011;

   // The low two opcode bits pick the branch condition
   localparam logic [1:0] condEqz = 2'b00;
   localparam logic [1:0] condNez = 2'b01;
   localparam logic [1:0] condLtz = 2'b10;
   localparam logic [1:0] condGez = 2'b11;

   // One instruction word seen through two field layouts
   // The register layout serves the write side and the read addresses
   // The branch layout splits the opcode into a class and a condition
   typedef union packed {
      struct packed {
         logic [opcodeWidth-1:0]  opcode;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rt;
         // Bits 4 to 0 hold rd or an immediate, both decoded elsewhere
         logic [4:0]              tail;
      } regFmt;
      struct packed {
         logic [2:0]              brClass;
         logic [1:0]              cond;
         logic [regAddrWidth-1:0] rs;
         // Branch displacement, extended and added in a later stage
         logic [7:0]              disp;
      } brFmt;
   } instrWord_t;

endpackage

/* design/registerFile.sv */
module registerFile
   import decodePkg::*;
(
   input  logic                    clk,
   input  logic                    reset,

   // Read port 1 address, which linkTracker may steer to the link register
   input  logic [regAddrWidth-1:0] read1Addr,

   // Read port 2 address, taken straight from the rt field
   input  logic [regAddrWidth-1:0] read2Addr,

   // Write port, already arbitrated by linkTracker
   input  logic [regAddrWidth-1:0] writeAddr,
   input  logic [dataWidth-1:0]    writeData,
   input  logic                    writeEn,

   // Read data, combinational from the addresses
   output logic [dataWidth-1:0]    read1Data,
   output logic [dataWidth-1:0]    read2Data
);

   // Number of registers addressed by the index width
   localparam int regCount = 2 ** regAddrWidth;

   // Register storage
   logic [dataWidth-1:0] regs [regCount];

   // Stored words seen by each read port before the bypass
   logic [dataWidth-1:0] stored1;
   logic [dataWidth-1:0] stored2;

   // A read of the register being written this cycle returns the new value
   // This lets writeback and decode share a cycle without a hazard bubble
   function automatic logic [dataWidth-1:0] bypassRead(
      input logic [regAddrWidth-1:0] readAddr,
      input logic [dataWidth-1:0]    storedWord,
      input logic [regAddrWidth-1:0] wrAddr,
      input logic [dataWidth-1:0]    wrData,
      input logic                    wrEn
   );
      logic hit;
      hit = wrEn && (wrAddr == readAddr);
      if (hit) begin
         return wrData;
      end
      return storedWord;
   endfunction

   // All registers start at zero so the first reads are defined
   // Writes land on the rising edge that closes the enabled cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Array lookups for both ports
   assign stored1 = regs[read1Addr];
   assign stored2 = regs[read2Addr];

   // Port 1 feeds the branch resolver as well as the top output
   assign read1Data = bypassRead(read1Addr, stored1, writeAddr, writeData, writeEn);

   // Port 2 only reaches the top output
   assign read2Data = bypassRead(read2Addr, stored2, writeAddr, writeData, writeEn);

endmodule

/* design/linkTracker.sv */
module linkTracker
   import decodePkg::*;
#(
   // Pipeline stages between decode and writeback
   parameter int linkDepth = 3
) (
   input  logic                    clk,
   input  logic                    reset,

   // Instruction currently in decode
   input  instrWord_t              instr,

   // PC used to form the return address
   input  logic [dataWidth-1:0]    pcNow,

   // Load-immediate value, already extended
   input  logic [dataWidth-1:0]    imm,

   // Result coming back from the writeback stage
   input  logic [dataWidth-1:0]    writeback,

   // Destination and enable of the instruction in writeback
   input  logic [regAddrWidth-1:0] writeRegAddr,
   input  logic                    writeEnable,

   // Selects imm over writeback for the write data
   input  logic                    lbi,

   // Later stage request for the return address as write data
   input  logic                    link,

   // Controls handed to the register file
   output logic [regAddrWidth-1:0] read1Addr,
   output logic [regAddrWidth-1:0] regWriteAddr,
   output logic [dataWidth-1:0]    regWriteData,
   output logic                    regWriteEn
);

   // High while decode holds JAL or JALR
   logic linkNow;

   // Bit 0 marks a link instruction one stage past decode, bit linkDepth-1 is at writeback
   logic [linkDepth-1:0] linkPipe;

   // Set while any link instruction is still on its way to writeback
   logic linkInFlight;

   // Return address of the instruction in decode
   logic [dataWidth-1:0] pcPlusTwo;

   // Non-link write data
   logic [dataWidth-1:0] normalData;

   // Both jump-and-link opcodes count as link instructions
   assign linkNow = (instr.regFmt.opcode == opJal) || (instr.regFmt.opcode == opJalr);

   // The flag follows the instruction down the pipe so its late write can be blocked
   always_ff @(posedge clk) begin
      if (reset) begin
         linkPipe <= '0;
      end else begin
         linkPipe[0] <= linkNow;
         for (int i = 1; i < linkDepth; i++) begin
            linkPipe[i] <= linkPipe[i-1];
         end
      end
   end

   assign linkInFlight = |linkPipe;

   // JAL reads register 7 on port 1, every other opcode reads rs
   assign read1Addr = (instr.regFmt.opcode == opJal) ? linkReg : instr.regFmt.rs;

   // A link instruction claims the write port for register 7 while in decode
   assign regWriteAddr = linkNow ? linkReg : writeRegAddr;

   // Own adder so the return address never waits on fetch
   assign pcPlusTwo = pcNow + dataWidth'(2);

   assign normalData = lbi ? imm : writeback;

   // The return address wins while a link instruction is in decode or just past it
   assign regWriteData = (link || linkNow || linkPipe[0]) ? pcPlusTwo : normalData;

   // Normal writes wait until no link instruction remains between decode and writeback
   // This keeps the link instruction's own late writeback from writing register 7 twice
   assign regWriteEn = linkNow || (writeEnable && !linkInFlight);

endmodule

/* design/branchResolver.sv */
module branchResolver
   import decodePkg::*;
(
   // Instruction in decode, read in its branch layout
   input  instrWord_t           instr,

   // Operand from read port 1, the rs register of a branch
   input  logic [dataWidth-1:0] reg1Data,

   // Forces branch treatment for opcodes outside the branch class
   input  logic                 bFlag,

   // Forces selection once the instruction is treated as a branch
   input  logic                 jFlag,

   // A halted processor never redirects the PC
   input  logic                 halt,

   // High when fetch must take the branch target
   output logic                 pcSel
);

   // Operand is all zeros
   logic zeroFlag;

   // Operand is negative in two's complement
   logic signFlag;

   // Instruction is handled as a branch
   logic isBranch;

   // The selected condition holds on the operand
   logic condMet;

   assign zeroFlag = (reg1Data == '0);
   assign signFlag = reg1Data[dataWidth-1];

   // Class match on the upper opcode bits or an explicit request
   assign isBranch = (instr.brFmt.brClass == branchClass) || bFlag;

   // The low opcode bits choose among the four zero and sign tests
   always_comb begin
      condMet = 1'b0;
      case (instr.brFmt.cond)
         // BEQZ
         condEqz: condMet = zeroFlag;
         // BNEZ
         condNez: condMet = !zeroFlag;
         // BLTZ
         condLtz: condMet = signFlag;
         // BGEZ
         condGez: condMet = !signFlag;
         default: condMet = 1'b0;
      endcase
   end

   // Halt wins over both the condition and the jump request
   assign pcSel = isBranch && !halt && (condMet || jFlag);

endmodule

/* design/decodeStage.sv */
module decodeStage
   import decodePkg::*;
#(
   // Pipeline stages between decode and writeback, at least 1
   parameter int linkDepth = 3
) (
   input  logic                    clk,
   input  logic                    reset,

   // Instruction word held in decode this cycle
   input  instrWord_t              instr,

   // Immediate for load-immediate, extended upstream
   input  logic [dataWidth-1:0]    imm,

   // Result returning from the writeback stage
   input  logic [dataWidth-1:0]    writeback,

   // Destination register of the instruction in writeback
   input  logic [regAddrWidth-1:0] writeRegAddr,

   // PC from which the return address is formed
   input  logic [dataWidth-1:0]    pcNow,

   // Write request from writeback
   input  logic                    writeEnable,

   // Picks imm rather than writeback as write data
   input  logic                    lbi,

   // Requests the return address as write data
   input  logic                    link,

   // Branch and jump qualifiers from the control unit
   input  logic                    bFlag,
   input  logic                    jFlag,
   input  logic                    halt,

   // Register operands for execute
   output logic [dataWidth-1:0]    reg1Data,
   output logic [dataWidth-1:0]    reg2Data,

   // Data presented to the register file write port
   output logic [dataWidth-1:0]    writeData,

   // Branch taken toward fetch
   output logic                    pcSel
);

   // Read address for port 1, steered to register 7 on JAL
   logic [regAddrWidth-1:0] read1Addr;

   // Write controls after link arbitration
   logic [regAddrWidth-1:0] regWriteAddr;
   logic                    regWriteEn;

   // Write side control, which owns every decision on register 7
   linkTracker #(
      .linkDepth(linkDepth)
   ) i_linkTracker (
      .clk         (clk),
      .reset       (reset),
      .instr       (instr),
      .pcNow       (pcNow),
      .imm         (imm),
      .writeback   (writeback),
      .writeRegAddr(writeRegAddr),
      .writeEnable (writeEnable),
      .lbi         (lbi),
      .link        (link),
      .read1Addr   (read1Addr),
      .regWriteAddr(regWriteAddr),
      .regWriteData(writeData),
      .regWriteEn  (regWriteEn)
   );

   // Storage, with port 2 addressed by rt directly
   registerFile i_registerFile (
      .clk      (clk),
      .reset    (reset),
      .read1Addr(read1Addr),
      .read2Addr(instr.regFmt.rt),
      .writeAddr(regWriteAddr),
      .writeData(writeData),
      .writeEn  (regWriteEn),
      .read1Data(reg1Data),
      .read2Data(reg2Data)
   );

   // Branch decision on the port 1 operand
   branchResolver i_branchResolver (
      .instr   (instr),
      .reg1Data(reg1Data),
      .bFlag   (bFlag),
      .jFlag   (jFlag),
      .halt    (halt),
      .pcSel   (pcSel)
   );

endmodule

/* tests/clockGen.sv */
module clockGen #(
   // Clock period in simulation time units
   parameter int period = 20,
   // Rising edges seen with reset held high
   parameter int resetCycles = 2
) (
   output logic clk,
   output logic reset
);

   // Free running clock that starts low
   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Reset drops on a falling edge, like every other DUT input
   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

/* tests/decodeStageTb.sv */
module decodeStageTb
   import decodePkg::*;
();

   localparam int linkDepthTb = 3;

   // Cycles spent in each test also size the timeout
   localparam int resetTestLen = 8;
   localparam int writeTestLen = 40;
   localparam int lbiTestLen = 16;
   localparam int jalTestLen = 14;
   localparam int branchTestLen = 48;
   localparam int cycleLimit = 2 * (3 + resetTestLen + writeTestLen + lbiTestLen
                                    + jalTestLen + branchTestLen);

   logic clk;
   logic reset;
   logic [15:0] instrBits;
   logic [15:0] imm;
   logic [15:0] writeback;
   logic [2:0] writeRegAddr;
   logic [15:0] pcNow;
   logic writeEnable;
   logic lbi;
   logic link;
   logic bFlag;
   logic jFlag;
   logic halt;
   logic [15:0] reg1Data;
   logic [15:0] reg2Data;
   logic [15:0] writeData;
   logic pcSel;

   // Reference model of the register contents and of the link blocking window
   logic [15:0] modelRegs [8];
   int linkCountdown;

   int testErrors;
   int passCount;
   int failCount;
   int cycleCount;
   logic [31:0] lfsrState;

   clockGen #(.period(20), .resetCycles(2)) i_clockGen (.clk(clk), .reset(reset));

   decodeStage #(.linkDepth(linkDepthTb)) i_decodeStage (
      .clk(clk), .reset(reset), .instr(instrBits), .imm(imm), .writeback(writeback),
      .writeRegAddr(writeRegAddr), .pcNow(pcNow), .writeEnable(writeEnable),
      .lbi(lbi), .link(link), .bFlag(bFlag), .jFlag(jFlag), .halt(halt),
      .reg1Data(reg1Data), .reg2Data(reg2Data), .writeData(writeData), .pcSel(pcSel)
   );

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h80200003;
      end
      return next;
   endfunction

   // One LFSR step per bit takes the bit that leaves the register
   task automatic randomBits(input int count, output logic [15:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[14:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      assert (actual === expected) else begin
         $display("ERROR time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         testErrors++;
      end
   endtask

   // Quiet inputs so each cycle only sets what it exercises
   task automatic driveDefaults();
      instrBits = '0;
      imm = '0;
      writeback = '0;
      writeRegAddr = '0;
      pcNow = '0;
      writeEnable = 1'b0;
      lbi = 1'b0;
      link = 1'b0;
      bFlag = 1'b0;
      jFlag = 1'b0;
      halt = 1'b0;
   endtask

   // Expected outputs follow from the stage rules and the model state
   task automatic checkCycle();
      logic [4:0] opcode;
      logic isLink;
      logic [2:0] r1Addr;
      logic [2:0] r2Addr;
      logic [2:0] wAddr;
      logic [15:0] wData;
      logic wEn;
      logic [15:0] exp1;
      logic [15:0] exp2;
      logic condHolds;
      logic isBranch;
      opcode = instrBits[15:11];
      isLink = (opcode == opJal) || (opcode == opJalr);
      r1Addr = (opcode == opJal) ? linkReg : instrBits[10:8];
      r2Addr = instrBits[7:5];
      wAddr = isLink ? linkReg : writeRegAddr;
      // A countdown at full depth means the previous cycle held a link instruction
      if (link || isLink || linkCountdown == linkDepthTb) begin
         wData = pcNow + 16'd2;
      end else begin
         wData = lbi ? imm : writeback;
      end
      wEn = isLink || (writeEnable && linkCountdown == 0);
      exp1 = (wEn && wAddr == r1Addr) ? wData : modelRegs[r1Addr];
      exp2 = (wEn && wAddr == r2Addr) ? wData : modelRegs[r2Addr];
      case (instrBits[12:11])
         2'b00: condHolds = (exp1 == 16'h0000);
         2'b01: condHolds = (exp1 != 16'h0000);
         2'b10: condHolds = exp1[15];
         default: condHolds = !exp1[15];
      endcase
      isBranch = (instrBits[15:13] == branchClass) || bFlag;
      checkValue("writeData", wData, writeData);
      checkValue("reg1Data", exp1, reg1Data);
      checkValue("reg2Data", exp2, reg2Data);
      checkValue("pcSel", {15'b0, isBranch && !halt && (condHolds || jFlag)}, {15'b0, pcSel});
      if (wEn) begin
         modelRegs[wAddr] = wData;
      end
      if (isLink) begin
         linkCountdown = linkDepthTb;
      end else if (linkCountdown > 0) begin
         linkCountdown--;
      end
   endtask

   // Inputs were set on the falling edge and outputs are checked on the rising edge
   task automatic runCycle();
      @(posedge clk);
      checkCycle();
      @(negedge clk);
   endtask

   task automatic finishTest(input string name);
      if (testErrors == 0) begin
         passCount++;
         $display("PASS %s", name);
      end else begin
         failCount++;
         $display("FAIL %s with %0d errors", name, testErrors);
      end
      testErrors = 0;
   endtask

   // Back to back normal writes where rs often hits the write address
   task automatic writeReadTest();
      logic [15:0] rnd;
      logic [2:0] rs;
      for (int i = 0; i < writeTestLen; i++) begin
         driveDefaults();
         randomBits(16, rnd);
         writeback = rnd;
         randomBits(3, rnd);
         writeRegAddr = rnd[2:0];
         randomBits(2, rnd);
         writeEnable = (rnd[1:0] != 2'b00);
         randomBits(6, rnd);
         rs = (i % 3 == 0) ? writeRegAddr : rnd[5:3];
         instrBits = {5'b00000, rs, rnd[2:0], 5'b00000};
         runCycle();
      end
      finishTest("normal write and read");
   endtask

   // Port 1 sees the bypassed immediate and port 2 the previous target
   task automatic loadImmTest();
      logic [15:0] rnd;
      logic [2:0] lastAddr;
      lastAddr = '0;
      for (int i = 0; i < lbiTestLen; i++) begin
         driveDefaults();
         lbi = 1'b1;
         writeEnable = 1'b1;
         randomBits(16, rnd);
         imm = rnd;
         randomBits(16, rnd);
         writeback = rnd;
         randomBits(3, rnd);
         writeRegAddr = rnd[2:0];
         instrBits = {5'b00000, writeRegAddr, lastAddr, 5'b00000};
         lastAddr = writeRegAddr;
         runCycle();
      end
      finishTest("load immediate");
   endtask

   // A link instruction is followed by three blocked writes to register 2
   // Then one write lands and a readback shows both registers
   task automatic linkSequence(input logic [4:0] linkOp);
      logic [15:0] rnd;
      driveDefaults();
      randomBits(15, rnd);
      pcNow = {rnd[14:0], 1'b0};
      writeEnable = 1'b1;
      writeRegAddr = 3'd3;
      instrBits = {linkOp, 3'd1, 3'd7, 5'b00000};
      runCycle();
      for (int i = 0; i < linkDepthTb + 1; i++) begin
         randomBits(16, rnd);
         writeback = rnd;
         writeRegAddr = 3'd2;
         instrBits = {5'b00000, 3'd7, 3'd2, 5'b00000};
         runCycle();
      end
      writeEnable = 1'b0;
      instrBits = {5'b00000, 3'd2, 3'd7, 5'b00000};
      runCycle();
   endtask

   task automatic jumpLinkTest();
      logic [15:0] rnd;
      linkSequence(opJal);
      linkSequence(opJalr);
      // A later stage asking for the return address on a plain write
      driveDefaults();
      link = 1'b1;
      writeEnable = 1'b1;
      writeRegAddr = 3'd5;
      randomBits(16, rnd);
      pcNow = rnd;
      runCycle();
      driveDefaults();
      instrBits = {5'b00000, 3'd5, 3'd5, 5'b00000};
      runCycle();
      finishTest("jump and link");
   endtask

   // The rs value is written in the same cycle and reaches the resolver through the bypass
   task automatic branchTest();
      logic [15:0] rnd;
      logic [15:0] value;
      logic [2:0] rs;
      logic [2:0] opClass;
      for (int i = 0; i < branchTestLen; i++) begin
         driveDefaults();
         randomBits(3, rnd);
         rs = rnd[2:0];
         randomBits(2, rnd);
         value = {rnd[1:0] == 2'b01, 15'b0};
         randomBits(15, rnd);
         // Every other group of four draws a full random operand for each condition
         // The remaining groups give mostly zero and sometimes a negative operand
         if (value != 16'h0000 || i % 8 >= 4) begin
            value = {value[15], rnd[14:0]};
         end
         randomBits(1, rnd);
         opClass = rnd[0] ? branchClass : 3'b100;
         randomBits(5, rnd);
         bFlag = rnd[0];
         jFlag = (rnd[2:1] == 2'b00);
         halt = (rnd[4:3] == 2'b00);
         randomBits(8, rnd);
         instrBits = {opClass, i[1:0], rs, rnd[7:0]};
         writeEnable = 1'b1;
         writeRegAddr = rs;
         writeback = value;
         runCycle();
      end
      finishTest("branches");
   endtask

   // Ends a run that stops making progress
   initial begin
      cycleCount = 0;
      while (cycleCount < cycleLimit) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("Verification failed");
      $finish;
   end

   initial begin
      lfsrState = 32'hfc0f;
      testErrors = 0;
      passCount = 0;
      failCount = 0;
      linkCountdown = 0;
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = '0;
      end
      driveDefaults();
      @(negedge reset);
      // Every register on both ports after reset
      for (int i = 0; i < resetTestLen; i++) begin
         driveDefaults();
         instrBits = {5'b00000, i[2:0], 3'(7 - i), 5'b00000};
         runCycle();
      end
      finishTest("reset");
      writeReadTest();
      loadImmTest();
      jumpLinkTest();
      branchTest();
      $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
design/decodePkg.sv
design/registerFile.sv
design/linkTracker.sv
design/branchResolver.sv
design/decodeStage.sv
tests/clockGen.sv
tests/decodeStageTb.sv
